// ==== cmd_regfile.sv ====
// holds the transmit request and drive level written by downstream commands
// addresses other than mox and drive are ignored
// drive comes out of reset at full scale

`timescale 1ns/1ps
`default_nettype none

module cmd_regfile (
  input  logic          clk_ctrl,
  input  logic          rst_n_i,
  input  sdr_pkg::cmd_t cmd_i,
  input  logic          cmd_stb_i,
  output logic          mox_o,
  output logic [7:0]    drive_o
);

  logic hit_mox;
  logic hit_drive;

  // address decode
  assign hit_mox   = cmd_stb_i && (cmd_i.addr == sdr_pkg::ADDR_MOX);
  assign hit_drive = cmd_stb_i && (cmd_i.addr == sdr_pkg::ADDR_DRIVE);

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mox_o   <= 1'b0;
      drive_o <= 8'hFF;
    end else begin
      if (hit_mox) begin
        mox_o <= cmd_i.data[0];
      end
      if (hit_drive) begin
        drive_o <= cmd_i.data[31:24];
      end
    end
  end

endmodule

`default_nettype wire

// ==== ds_frame_parser.sv ====
// walks downstream frames byte by byte, frames end when valid falls
// needs at least one idle cycle between frames
// a partial trailing i/q group is dropped

`timescale 1ns/1ps
`default_nettype none

module ds_frame_parser (
  input  logic                clk_ctrl,
  input  logic                rst_n_i,
  input  sdr_pkg::eth_byte_t  eth_i,
  output sdr_pkg::cmd_t       cmd_o,
  output logic                cmd_stb_o,
  output sdr_pkg::tx_sample_t wr_data_o,
  output logic                wr_en_o,
  output logic                run_o,
  output logic                wide_spectrum_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HEADER,
    ST_START,
    ST_CMD,
    ST_SAMPLES,
    ST_DISCARD
  } state_t;

  state_t      state_q;
  // counts bytes in the frame, wraps so the sample phase is the low two bits
  logic [2:0]  byte_cnt_q;
  // first three bytes of the sample being assembled
  logic [23:0] samp_sr_q;
  logic        cmd_done;
  logic        sample_done;

  assign cmd_done    = eth_i.valid && (state_q == ST_CMD) && (byte_cnt_q == 3'd7);
  assign sample_done = eth_i.valid && (state_q == ST_SAMPLES) && (byte_cnt_q[1:0] == 2'd3);

  ////////////////////////////////////////////////////////////////////////////
  // frame state machine

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q         <= ST_IDLE;
      byte_cnt_q      <= '0;
      cmd_stb_o       <= 1'b0;
      wr_en_o         <= 1'b0;
      run_o           <= 1'b0;
      wide_spectrum_o <= 1'b0;
    end else begin
      cmd_stb_o <= cmd_done;
      wr_en_o   <= sample_done;
      if (!eth_i.valid) begin
        state_q    <= ST_IDLE;
        byte_cnt_q <= '0;
      end else begin
        byte_cnt_q <= byte_cnt_q + 3'd1;
        case (state_q)
          ST_IDLE: begin
            // port and first sync byte arrive together
            if ((eth_i.port == sdr_pkg::DS_PORT) && (eth_i.data == sdr_pkg::SYNC0)) begin
              state_q <= ST_HEADER;
            end else begin
              state_q <= ST_DISCARD;
            end
          end
          ST_HEADER: begin
            if (byte_cnt_q == 3'd1) begin
              if (eth_i.data != sdr_pkg::SYNC1) begin
                state_q <= ST_DISCARD;
              end
            end else if (eth_i.data == sdr_pkg::TYPE_START) begin
              state_q <= ST_START;
            end else if (eth_i.data == sdr_pkg::TYPE_DATA) begin
              state_q <= ST_CMD;
            end else begin
              state_q <= ST_DISCARD;
            end
          end
          ST_START: begin
            run_o           <= eth_i.data[0];
            wide_spectrum_o <= eth_i.data[1];
            // rest of a start/stop frame carries nothing for us
            state_q         <= ST_DISCARD;
          end
          ST_CMD: begin
            if (cmd_done) begin
              state_q <= ST_SAMPLES;
            end
          end
          ST_SAMPLES: begin
            state_q <= ST_SAMPLES;
          end
          default: begin
            state_q <= ST_DISCARD;
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // command and sample assembly

  always_ff @(posedge clk_ctrl) begin
    if (eth_i.valid && (state_q == ST_CMD)) begin
      if (byte_cnt_q == 3'd3) begin
        cmd_o.addr <= eth_i.data[6:1];
      end else begin
        // msb first
        cmd_o.data <= {cmd_o.data[23:0], eth_i.data};
      end
    end
    if (eth_i.valid && (state_q == ST_SAMPLES)) begin
      samp_sr_q <= {samp_sr_q[15:0], eth_i.data};
      if (sample_done) begin
        wr_data_o.i <= samp_sr_q[23:8];
        wr_data_o.q <= {samp_sr_q[7:0], eth_i.data};
      end
    end
  end

endmodule

`default_nettype wire

// ==== sample_fifo.sv ====
// show-ahead sample buffer, the head is visible while not empty
// FIFO_DEPTH must be a power of two, at least 2
// writes into a full buffer are dropped and set a sticky overflow flag

`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                            clk_ctrl,
  input  logic                            rst_n_i,
  input  sdr_pkg::tx_sample_t             wr_data_i,
  input  logic                            wr_en_i,
  input  logic                            rd_en_i,
  output sdr_pkg::tx_sample_t             rd_data_o,
  output logic                            empty_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] level_o,
  output logic                            overflow_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

  sdr_pkg::tx_sample_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             full;
  logic             wr_ok;
  logic             rd_ok;

  assign full      = (level_o == LVL_W'(FIFO_DEPTH));
  assign empty_o   = (level_o == '0);
  assign wr_ok     = wr_en_i && !full;
  assign rd_ok     = rd_en_i && !empty_o;
  assign rd_data_o = mem[rd_ptr_q];

  always_ff @(posedge clk_ctrl) begin
    if (wr_ok) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  // pointers wrap naturally with a power of two depth
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_o    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   level_o <= level_o + 1'b1;
        2'b01:   level_o <= level_o - 1'b1;
        default: level_o <= level_o;
      endcase
      if (wr_en_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks

  // the pacer must look at empty before it pops
  a_no_pop_when_empty: assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i) rd_en_i |-> !empty_o
  ) else $error("sample_fifo: pop while empty");

  a_level_bound: assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i) level_o <= LVL_W'(FIFO_DEPTH)
  ) else $error("sample_fifo: level above depth");

endmodule

`default_nettype wire

// ==== sdr_ds_top.sv ====
// downstream transmit path, everything on clk_ctrl
// no back-pressure on eth_i, overflow is reported instead
// tx_inhibit_i is taken as already synchronous

`timescale 1ns/1ps
`default_nettype none

module sdr_ds_top #(
  parameter int FIFO_DEPTH = 16,
  parameter int SAMPLE_DIV = 8
) (
  input  logic                            clk_ctrl,
  input  logic                            rst_n_i,
  input  sdr_pkg::eth_byte_t              eth_i,
  input  logic                            tx_inhibit_i,
  output sdr_pkg::tx_sample_t             dac_o,
  output logic                            dac_valid_o,
  output logic                            tx_on_o,
  output logic                            run_o,
  output logic                            wide_spectrum_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_level_o,
  output logic                            overflow_o,
  output logic [7:0]                      underflow_o
);

  sdr_pkg::cmd_t       cmd;
  logic                cmd_stb;
  sdr_pkg::tx_sample_t wr_data;
  logic                wr_en;
  sdr_pkg::tx_sample_t rd_data;
  logic                rd_en;
  logic                empty;
  logic                mox;
  logic [7:0]          drive;

  ////////////////////////////////////////////////////////////////////////////
  // producer side

  ds_frame_parser u_parser (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .eth_i           (eth_i),
    .cmd_o           (cmd),
    .cmd_stb_o       (cmd_stb),
    .wr_data_o       (wr_data),
    .wr_en_o         (wr_en),
    .run_o           (run_o),
    .wide_spectrum_o (wide_spectrum_o)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_ctrl   (clk_ctrl),
    .rst_n_i    (rst_n_i),
    .wr_data_i  (wr_data),
    .wr_en_i    (wr_en),
    .rd_en_i    (rd_en),
    .rd_data_o  (rd_data),
    .empty_o    (empty),
    .level_o    (fifo_level_o),
    .overflow_o (overflow_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // consumer side

  cmd_regfile u_regs (
    .clk_ctrl  (clk_ctrl),
    .rst_n_i   (rst_n_i),
    .cmd_i     (cmd),
    .cmd_stb_i (cmd_stb),
    .mox_o     (mox),
    .drive_o   (drive)
  );

  tx_sample_pacer #(
    .SAMPLE_DIV (SAMPLE_DIV)
  ) u_pacer (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .run_i        (run_o),
    .mox_i        (mox),
    .tx_inhibit_i (tx_inhibit_i),
    .drive_i      (drive),
    .rd_data_i    (rd_data),
    .empty_i      (empty),
    .rd_en_o      (rd_en),
    .dac_o        (dac_o),
    .dac_valid_o  (dac_valid_o),
    .tx_on_o      (tx_on_o),
    .underflow_o  (underflow_o)
  );

endmodule

`default_nettype wire

// ==== sdr_pkg.sv ====
// shared constants and struct types for the downstream transmit path
// frame layout follows the openhpsdr protocol 1 start/stop and data frames
// transmit samples are 16 bit signed i/q pairs, i in the upper half

`default_nettype none

package sdr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // frame constants

  // udp destination port for downstream frames
  localparam logic [15:0] DS_PORT    = 16'd1024;

  localparam logic [7:0]  SYNC0      = 8'hEF;
  localparam logic [7:0]  SYNC1      = 8'hFE;
  localparam logic [7:0]  TYPE_START = 8'h04;
  localparam logic [7:0]  TYPE_DATA  = 8'h01;

  ////////////////////////////////////////////////////////////////////////////
  // command address map

  // bit 0 of data is the transmit request
  localparam logic [5:0]  ADDR_MOX   = 6'h00;
  // data bits 31..24 hold the drive level
  localparam logic [5:0]  ADDR_DRIVE = 6'h09;

  ////////////////////////////////////////////////////////////////////////////
  // shared types

  // one payload byte, valid stays high for the whole frame
  typedef struct packed {
    logic        valid;
    logic [15:0] port;
    logic [7:0]  data;
  } eth_byte_t;

  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
  } cmd_t;

  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } tx_sample_t;

endpackage

`default_nettype wire

// ==== sim.f ====
sdr_pkg.sv
ds_frame_parser.sv
sample_fifo.sv
cmd_regfile.sv
tx_sample_pacer.sv
sdr_ds_top.sv
tb_sdr_ds.sv

// ==== tb_sdr_ds.sv ====
// testbench for the downstream transmit path, default FIFO_DEPTH and SAMPLE_DIV
// samples are only loaded while transmission is gated, so the reference
// queue never races the buffer

`timescale 1ns/1ps
`default_nettype none

module tb_sdr_ds;

  localparam int FIFO_DEPTH = 16;
  localparam logic [5:0] ADDR_UNUSED = 6'h3F;

  logic                clk_ctrl;
  logic                rst_n_i;
  sdr_pkg::eth_byte_t  eth_i;
  logic                tx_inhibit_i;
  sdr_pkg::tx_sample_t dac_o;
  logic                dac_valid_o;
  logic                tx_on_o;
  logic                run_o;
  logic                wide_spectrum_o;
  logic [4:0]          fifo_level_o;
  logic                overflow_o;
  logic [7:0]          underflow_o;

  // reference model state
  sdr_pkg::tx_sample_t exp_q[$];
  sdr_pkg::tx_sample_t exp_head = '0;
  logic                exp_empty = 1'b1;
  logic                exp_run = 1'b0;
  logic                exp_wide = 1'b0;
  logic [7:0]          exp_drive = 8'hFF;
  logic                pend_run = 1'b0;
  logic                pend_wide = 1'b0;
  logic [7:0]          pend_drive = 8'hFF;

  // windows in which a check applies
  logic ignore_win = 1'b0;
  logic hold_off = 1'b0;
  logic ovf_allowed = 1'b0;
  logic ovf_expect = 1'b0;

  logic [7:0]  frame_q[$];
  logic [31:0] lfsr_state = 32'h0786c3f4;

  sdr_ds_top uut (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .eth_i           (eth_i),
    .tx_inhibit_i    (tx_inhibit_i),
    .dac_o           (dac_o),
    .dac_valid_o     (dac_valid_o),
    .tx_on_o         (tx_on_o),
    .run_o           (run_o),
    .wide_spectrum_o (wide_spectrum_o),
    .fifo_level_o    (fifo_level_o),
    .overflow_o      (overflow_o),
    .underflow_o     (underflow_o)
  );

  initial begin
    clk_ctrl = 1'b0;
    forever #2 clk_ctrl = ~clk_ctrl;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic fail_now(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  // galois lfsr, one step per bit taken
  function automatic logic [15:0] rand16();
    logic [15:0] v;
    v = '0;
    for (int b = 0; b < 16; b++) begin
      v = {v[14:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return v;
  endfunction

  // component times drive, arithmetic shift by 8, low 16 bits kept
  function automatic logic [15:0] ref_scale(input logic signed [15:0] x,
                                            input logic [7:0] d);
    int p;
    p = int'(x) * int'({24'd0, d});
    p = p >>> 8;
    return p[15:0];
  endfunction

  task automatic put_header(input logic [7:0] s0, input logic [7:0] s1,
                            input logic [7:0] ty);
    frame_q.push_back(s0);
    frame_q.push_back(s1);
    frame_q.push_back(ty);
  endtask

  task automatic put_command(input logic [5:0] addr, input logic [31:0] data);
    frame_q.push_back({1'b0, addr, 1'b0});
    frame_q.push_back(data[31:24]);
    frame_q.push_back(data[23:16]);
    frame_q.push_back(data[15:8]);
    frame_q.push_back(data[7:0]);
  endtask

  task automatic put_samples(input int n, input bit track);
    sdr_pkg::tx_sample_t s;
    for (int k = 0; k < n; k++) begin
      s.i = rand16();
      s.q = rand16();
      frame_q.push_back(s.i[15:8]);
      frame_q.push_back(s.i[7:0]);
      frame_q.push_back(s.q[15:8]);
      frame_q.push_back(s.q[7:0]);
      if (track) begin
        exp_q.push_back(s);
      end
    end
  endtask

  // model levels follow on the edge where valid falls
  task automatic send_frame(input logic [15:0] port);
    foreach (frame_q[k]) begin
      @(posedge clk_ctrl);
      eth_i.valid <= 1'b1;
      eth_i.port  <= port;
      eth_i.data  <= frame_q[k];
    end
    @(posedge clk_ctrl);
    eth_i     <= '0;
    exp_run   <= pend_run;
    exp_wide  <= pend_wide;
    exp_drive <= pend_drive;
    frame_q.delete();
    repeat (3) @(posedge clk_ctrl);
  endtask

  task automatic send_start(input logic run, input logic wide);
    pend_run  = run;
    pend_wide = wide;
    put_header(sdr_pkg::SYNC0, sdr_pkg::SYNC1, sdr_pkg::TYPE_START);
    frame_q.push_back({6'd0, wide, run});
    repeat (4) frame_q.push_back(8'h00);
    send_frame(sdr_pkg::DS_PORT);
  endtask

  task automatic send_cmd(input logic [5:0] addr, input logic [31:0] data,
                          input int n, input bit track);
    put_header(sdr_pkg::SYNC0, sdr_pkg::SYNC1, sdr_pkg::TYPE_DATA);
    put_command(addr, data);
    put_samples(n, track);
    send_frame(sdr_pkg::DS_PORT);
  endtask

  task automatic wait_outputs(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(posedge clk_ctrl);
      if (dac_valid_o) begin
        seen++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference queue, head is the expected value of the next output

  always @(posedge clk_ctrl) begin
    if (dac_valid_o && (exp_q.size() > 0)) begin
      void'(exp_q.pop_front());
    end
    if (exp_q.size() > 0) begin
      exp_head.i <= ref_scale(exp_q[0].i, exp_drive);
      exp_head.q <= ref_scale(exp_q[0].q, exp_drive);
      exp_empty  <= 1'b0;
    end else begin
      exp_head  <= '0;
      exp_empty <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks

  a_run_level: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    !eth_i.valid |-> (run_o == exp_run) && (wide_spectrum_o == exp_wide)
  ) else fail_now("run or wide_spectrum level differs from the last start frame");

  a_ignored: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    ignore_win |-> $stable(fifo_level_o) && $stable(tx_on_o)
  ) else fail_now("ignored frame changed fifo level or transmit state");

  a_sample_value: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    (dac_valid_o && !exp_empty) |->
      (dac_o == exp_head) && (underflow_o == $past(underflow_o))
  ) else fail_now("dac sample does not match the scaled reference");

  a_underflow: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    (dac_valid_o && exp_empty) |->
      (dac_o == '0) && (underflow_o == $past(underflow_o) + 8'd1)
  ) else fail_now("underflow output not zero or count not advanced by one");

  a_underflow_quiet: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    !dac_valid_o |-> $stable(underflow_o)
  ) else fail_now("underflow count moved without an output");

  a_gated: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    hold_off |-> !tx_on_o && !dac_valid_o && (fifo_level_o >= $past(fifo_level_o))
  ) else fail_now("transmit activity while inhibited or mox clear");

  a_no_overflow: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    !ovf_allowed |-> !overflow_o
  ) else fail_now("overflow flagged before the buffer was overfilled");

  a_overflow: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    ovf_expect |-> (fifo_level_o == 5'(FIFO_DEPTH)) && overflow_o
  ) else fail_now("overfilled buffer not at full level with overflow set");

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    rst_n_i      = 1'b0;
    eth_i        = '0;
    tx_inhibit_i = 1'b0;
    repeat (3) @(posedge clk_ctrl);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_ctrl);

    // start and stop
    send_start(1'b1, 1'b1);
    send_start(1'b0, 1'b0);
    send_start(1'b1, 1'b0);

    // bad port, sync and type, each would set mox or load samples if taken
    ignore_win <= 1'b1;
    put_header(sdr_pkg::SYNC0, sdr_pkg::SYNC1, sdr_pkg::TYPE_DATA);
    put_command(sdr_pkg::ADDR_MOX, 32'd1);
    put_samples(3, 1'b0);
    send_frame(sdr_pkg::DS_PORT + 16'd1);
    put_header(sdr_pkg::SYNC0, sdr_pkg::SYNC1, sdr_pkg::TYPE_START);
    frame_q.push_back(8'h00);
    send_frame(16'd1025);
    put_header(sdr_pkg::SYNC0, 8'hFF, sdr_pkg::TYPE_DATA);
    put_command(sdr_pkg::ADDR_MOX, 32'd1);
    put_samples(3, 1'b0);
    send_frame(sdr_pkg::DS_PORT);
    put_header(sdr_pkg::SYNC0, sdr_pkg::SYNC1, 8'h02);
    put_command(sdr_pkg::ADDR_MOX, 32'd1);
    put_samples(3, 1'b0);
    send_frame(sdr_pkg::DS_PORT);
    ignore_win <= 1'b0;

    // load with mox clear, a trailing half sample must be dropped
    hold_off   <= 1'b1;
    pend_drive = 8'h80;
    put_header(sdr_pkg::SYNC0, sdr_pkg::SYNC1, sdr_pkg::TYPE_DATA);
    put_command(sdr_pkg::ADDR_DRIVE, 32'h8000_0000);
    put_samples(5, 1'b1);
    frame_q.push_back(8'h5A);
    frame_q.push_back(8'hA5);
    send_frame(sdr_pkg::DS_PORT);
    send_cmd(ADDR_UNUSED, 32'hFFFF_FFFF, 6, 1'b1);
    repeat (40) @(posedge clk_ctrl);
    hold_off <= 1'b0;

    // transmit, drain, then a few underflow outputs
    send_cmd(sdr_pkg::ADDR_MOX, 32'd1, 0, 1'b0);
    while (exp_q.size() != 0) @(posedge clk_ctrl);
    wait_outputs(3);

    // inhibit while loading under a second drive level
    tx_inhibit_i <= 1'b1;
    repeat (2) @(posedge clk_ctrl);
    hold_off   <= 1'b1;
    pend_drive = 8'h3C;
    send_cmd(sdr_pkg::ADDR_DRIVE, 32'h3C00_0000, 8, 1'b1);
    repeat (40) @(posedge clk_ctrl);
    hold_off     <= 1'b0;
    tx_inhibit_i <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk_ctrl);
    wait_outputs(2);

    // overfill with mox clear
    send_cmd(sdr_pkg::ADDR_MOX, 32'd0, 0, 1'b0);
    hold_off    <= 1'b1;
    ovf_allowed <= 1'b1;
    send_cmd(ADDR_UNUSED, 32'd0, FIFO_DEPTH + 4, 1'b0);
    ovf_expect <= 1'b1;
    repeat (10) @(posedge clk_ctrl);

    $display("Regression passed");
    $finish;
  end

  // well above the stimulus length
  initial begin
    #20000;
    $display("timeout: stimulus did not finish");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== tx_sample_pacer.sv ====
// pops one sample every SAMPLE_DIV cycles while transmitting, SAMPLE_DIV >= 2
// output is i/q times drive, arithmetic shift right by 8
// an empty buffer at a tick gives a zero output and counts an underflow

`timescale 1ns/1ps
`default_nettype none

module tx_sample_pacer #(
  parameter int SAMPLE_DIV = 8
) (
  input  logic                clk_ctrl,
  input  logic                rst_n_i,
  input  logic                run_i,
  input  logic                mox_i,
  input  logic                tx_inhibit_i,
  input  logic [7:0]          drive_i,
  input  sdr_pkg::tx_sample_t rd_data_i,
  input  logic                empty_i,
  output logic                rd_en_o,
  output sdr_pkg::tx_sample_t dac_o,
  output logic                dac_valid_o,
  output logic                tx_on_o,
  output logic [7:0]          underflow_o
);

  localparam int DIV_W = $clog2(SAMPLE_DIV);

  logic [DIV_W-1:0] div_cnt_q;
  logic             tick;
  logic             tx_on_d;
  logic             xmit;
  logic             fire;

  function automatic logic signed [15:0] scale(input logic signed [15:0] x,
                                               input logic [7:0] d);
    logic signed [24:0] prod;
    logic signed [24:0] shifted;
    prod    = x * $signed({1'b0, d});
    shifted = prod >>> 8;
    return shifted[15:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // sample tick

  assign tick = (div_cnt_q == DIV_W'(SAMPLE_DIV - 1));

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_cnt_q <= '0;
    end else if (tick) begin
      div_cnt_q <= '0;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // transmit gating and output

  assign tx_on_d = run_i && mox_i && !tx_inhibit_i;
  // only emit when transmit holds this cycle and the next, so an output
  // never lands on a cycle where tx_on_o has dropped
  assign xmit    = tx_on_o && tx_on_d;
  assign fire    = tick && xmit;
  assign rd_en_o = fire && !empty_i;

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_on_o     <= 1'b0;
      dac_valid_o <= 1'b0;
      underflow_o <= '0;
    end else begin
      tx_on_o     <= tx_on_d;
      dac_valid_o <= fire;
      // saturating count
      if (fire && empty_i && (underflow_o != 8'hFF)) begin
        underflow_o <= underflow_o + 8'd1;
      end
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (fire) begin
      if (empty_i) begin
        dac_o <= '0;
      end else begin
        dac_o.i <= scale(rd_data_i.i, drive_i);
        dac_o.q <= scale(rd_data_i.q, drive_i);
      end
    end
  end

  a_valid_only_tx: assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i) dac_valid_o |-> tx_on_o
  ) else $error("tx_sample_pacer: dac output while not transmitting");

endmodule

`default_nettype wire
